// File: rtl/rvIsaPkg.sv
package rvIsaPkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;

    // major opcodes handled by this pipeline
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

endpackage

// File: rtl/pipeCtrlPkg.sv
package pipeCtrlPkg;

    // alu-op class from the decoder, zero is plain add
    typedef enum logic [1:0] {
        aluAdd    = 2'd0,
        aluBranch = 2'd1,
        aluReg    = 2'd2,
        aluImm    = 2'd3
    } aluOpT;

    typedef enum logic [2:0] {
        immNone = 3'd0,
        immI    = 3'd1,
        immS    = 3'd2,
        immB    = 3'd3,
        immU    = 3'd4
    } immTypeT;

    typedef enum logic [3:0] {
        fnAdd  = 4'd0,
        fnSub  = 4'd1,
        fnSll  = 4'd2,
        fnSlt  = 4'd3,
        fnSltu = 4'd4,
        fnXor  = 4'd5,
        fnSrl  = 4'd6,
        fnSra  = 4'd7,
        fnOr   = 4'd8,
        fnAnd  = 4'd9
    } aluFuncT;

endpackage

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]                   instr,
    output logic [rvIsaPkg::regAddrW-1:0] rs1Addr,
    output logic [rvIsaPkg::regAddrW-1:0] rs2Addr,
    output logic [rvIsaPkg::regAddrW-1:0] writeAddr,
    output logic [2:0]                    funct3,
    output logic [6:0]                    funct7,
    output logic [rvIsaPkg::xlen-1:0]     imm,
    output pipeCtrlPkg::aluOpT            aluOp,
    output logic                          aluSrc,
    output logic                          rdSrc,
    output logic                          memtoReg,
    output logic                          memWrite,
    output logic                          memRead,
    output logic                          regWrite,
    output logic                          branch
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    opcodeT opcode;
    immTypeT immType;

    assign opcode = opcodeT'(instr[6:0]);

    // lui reads x0 so the alu adds the U immediate to zero
    assign rs1Addr = (opcode == opLui) ? '0 : instr[19:15];
    assign rs2Addr = instr[24:20];
    assign writeAddr = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        aluOp = aluAdd;
        immType = immNone;
        aluSrc = 1'b0;
        rdSrc = 1'b0;
        memtoReg = 1'b0;
        memWrite = 1'b0;
        memRead = 1'b0;
        regWrite = 1'b0;
        branch = 1'b0;
        case (opcode)
            opLoad: begin
                immType = immI;
                aluSrc = 1'b1;
                memtoReg = 1'b1;
                memRead = 1'b1;
                regWrite = 1'b1;
            end
            opStore: begin
                immType = immS;
                aluSrc = 1'b1;
                memWrite = 1'b1;
            end
            opBranch: begin
                aluOp = aluBranch;
                immType = immB;
                branch = 1'b1;
            end
            opOpImm: begin
                aluOp = aluImm;
                immType = immI;
                aluSrc = 1'b1;
                regWrite = 1'b1;
            end
            opOp: begin
                aluOp = aluReg;
                regWrite = 1'b1;
            end
            opLui: begin
                immType = immU;
                aluSrc = 1'b1;
                regWrite = 1'b1;
            end
            opAuipc: begin
                immType = immU;
                rdSrc = 1'b1;
                regWrite = 1'b1;
            end
            // unknown opcode leaves a bubble
            default: ;
        endcase
    end

    always_comb begin
        case (immType)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rvIsaPkg::regAddrW-1:0] rs1Addr,
    input  logic [rvIsaPkg::regAddrW-1:0] rs2Addr,
    output logic [rvIsaPkg::xlen-1:0]     rs1Data,
    output logic [rvIsaPkg::xlen-1:0]     rs2Data,
    input  logic                          wbWe,
    input  logic [rvIsaPkg::regAddrW-1:0] wbAddr,
    input  logic [rvIsaPkg::xlen-1:0]     wbData
);
    import rvIsaPkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] readReg(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wbWe && (wbAddr == addr)) begin
            // same-cycle write seen by the reader
            return wbData;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

endmodule

// File: rtl/idExeReg.sv
`timescale 1ns/1ps

module idExeReg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic [rvIsaPkg::xlen-1:0]     pc,
    input  logic [rvIsaPkg::xlen-1:0]     rs1Data,
    input  logic [rvIsaPkg::xlen-1:0]     rs2Data,
    input  logic [rvIsaPkg::xlen-1:0]     imm,
    input  logic [rvIsaPkg::regAddrW-1:0] writeAddr,
    input  logic [2:0]                    funct3,
    input  logic [6:0]                    funct7,
    input  pipeCtrlPkg::aluOpT            aluOp,
    input  logic                          aluSrc,
    input  logic                          rdSrc,
    input  logic                          memtoReg,
    input  logic                          memWrite,
    input  logic                          memRead,
    input  logic                          regWrite,
    input  logic                          branch,
    output logic [rvIsaPkg::xlen-1:0]     exePc,
    output logic [rvIsaPkg::xlen-1:0]     exeRs1Data,
    output logic [rvIsaPkg::xlen-1:0]     exeRs2Data,
    output logic [rvIsaPkg::xlen-1:0]     exeImm,
    output logic [rvIsaPkg::regAddrW-1:0] exeWriteAddr,
    output logic [2:0]                    exeFunct3,
    output logic [6:0]                    exeFunct7,
    output pipeCtrlPkg::aluOpT            exeAluOp,
    output logic                          exeAluSrc,
    output logic                          exeRdSrc,
    output logic                          exeMemtoReg,
    output logic                          exeMemWrite,
    output logic                          exeMemRead,
    output logic                          exeRegWrite,
    output logic                          exeBranch
);
    import pipeCtrlPkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exePc <= '0;
            exeRs1Data <= '0;
            exeRs2Data <= '0;
            exeImm <= '0;
            exeWriteAddr <= '0;
            exeFunct3 <= '0;
            exeFunct7 <= '0;
            exeAluOp <= aluAdd;
            exeAluSrc <= 1'b0;
            exeRdSrc <= 1'b0;
            exeMemtoReg <= 1'b0;
            exeMemWrite <= 1'b0;
            exeMemRead <= 1'b0;
            exeRegWrite <= 1'b0;
            exeBranch <= 1'b0;
        end else begin
            // flush turns the slot into an all-zero bubble
            exePc <= flush ? '0 : pc;
            exeRs1Data <= flush ? '0 : rs1Data;
            exeRs2Data <= flush ? '0 : rs2Data;
            exeImm <= flush ? '0 : imm;
            exeWriteAddr <= flush ? '0 : writeAddr;
            exeFunct3 <= flush ? '0 : funct3;
            exeFunct7 <= flush ? '0 : funct7;
            exeAluOp <= flush ? aluAdd : aluOp;
            exeAluSrc <= flush ? 1'b0 : aluSrc;
            exeRdSrc <= flush ? 1'b0 : rdSrc;
            exeMemtoReg <= flush ? 1'b0 : memtoReg;
            exeMemWrite <= flush ? 1'b0 : memWrite;
            exeMemRead <= flush ? 1'b0 : memRead;
            exeRegWrite <= flush ? 1'b0 : regWrite;
            exeBranch <= flush ? 1'b0 : branch;
        end
    end

endmodule

// File: rtl/exeStage.sv
`timescale 1ns/1ps

module exeStage (
    input  logic [rvIsaPkg::xlen-1:0] exePc,
    input  logic [rvIsaPkg::xlen-1:0] exeRs1Data,
    input  logic [rvIsaPkg::xlen-1:0] exeRs2Data,
    input  logic [rvIsaPkg::xlen-1:0] exeImm,
    input  logic [2:0]                exeFunct3,
    input  logic [6:0]                exeFunct7,
    input  pipeCtrlPkg::aluOpT        exeAluOp,
    input  logic                      exeAluSrc,
    input  logic                      exeRdSrc,
    input  logic                      exeBranch,
    output logic [rvIsaPkg::xlen-1:0] exeResult,
    output logic [rvIsaPkg::xlen-1:0] exeStoreData,
    output logic [rvIsaPkg::xlen-1:0] branchTarget,
    output logic                      branchTaken
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    aluFuncT aluFunc;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [4:0] shamt;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] pcPlusImm;
    logic condMet;

    // alu control
    always_comb begin
        aluFunc = fnAdd;
        case (exeAluOp)
            aluBranch: aluFunc = fnSub;
            aluReg, aluImm: begin
                case (exeFunct3)
                    // only R-type has sub, addi ignores funct7
                    3'b000: aluFunc = (exeAluOp == aluReg && exeFunct7[5]) ? fnSub : fnAdd;
                    3'b001: aluFunc = fnSll;
                    3'b010: aluFunc = fnSlt;
                    3'b011: aluFunc = fnSltu;
                    3'b100: aluFunc = fnXor;
                    3'b101: aluFunc = exeFunct7[5] ? fnSra : fnSrl;
                    3'b110: aluFunc = fnOr;
                    default: aluFunc = fnAnd;
                endcase
            end
            default: aluFunc = fnAdd;
        endcase
    end

    assign opA = exeRs1Data;
    assign opB = exeAluSrc ? exeImm : exeRs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluFunc)
            fnSub: aluOut = opA - opB;
            fnSll: aluOut = opA << shamt;
            fnSlt: aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            fnSltu: aluOut = {{(xlen-1){1'b0}}, opA < opB};
            fnXor: aluOut = opA ^ opB;
            fnSrl: aluOut = opA >> shamt;
            fnSra: aluOut = $unsigned($signed(opA) >>> shamt);
            fnOr: aluOut = opA | opB;
            fnAnd: aluOut = opA & opB;
            default: aluOut = opA + opB;
        endcase
    end

    // shared by auipc and branch target
    assign pcPlusImm = exePc + exeImm;

    always_comb begin
        case (branchCondT'(exeFunct3))
            brEq: condMet = (exeRs1Data == exeRs2Data);
            brNe: condMet = (exeRs1Data != exeRs2Data);
            brLt: condMet = ($signed(exeRs1Data) < $signed(exeRs2Data));
            brGe: condMet = ($signed(exeRs1Data) >= $signed(exeRs2Data));
            brLtu: condMet = (exeRs1Data < exeRs2Data);
            brGeu: condMet = (exeRs1Data >= exeRs2Data);
            default: condMet = 1'b0;
        endcase
    end

    assign exeResult = exeRdSrc ? pcPlusImm : aluOut;
    assign exeStoreData = exeRs2Data;
    assign branchTarget = pcPlusImm;
    assign branchTaken = exeBranch && condMet;

endmodule

// File: rtl/decodeExecuteTop.sv
`timescale 1ns/1ps

module decodeExecuteTop (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   instr,
    input  logic [rvIsaPkg::xlen-1:0]     pc,
    input  logic                          flush,
    input  logic                          wbWe,
    input  logic [rvIsaPkg::regAddrW-1:0] wbAddr,
    input  logic [rvIsaPkg::xlen-1:0]     wbData,
    output logic [rvIsaPkg::xlen-1:0]     exeResult,
    output logic [rvIsaPkg::xlen-1:0]     exeStoreData,
    output logic [rvIsaPkg::regAddrW-1:0] exeWriteAddr,
    output logic [2:0]                    exeFunct3,
    output logic                          exeRegWrite,
    output logic                          exeMemRead,
    output logic                          exeMemWrite,
    output logic                          exeMemtoReg,
    output logic                          branchTaken,
    output logic [rvIsaPkg::xlen-1:0]     branchTarget
);
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    // decode side
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [regAddrW-1:0] writeAddr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    aluOpT aluOp;
    logic aluSrc;
    logic rdSrc;
    logic memtoReg;
    logic memWrite;
    logic memRead;
    logic regWrite;
    logic branch;

    // execute side
    logic [xlen-1:0] exePc;
    logic [xlen-1:0] exeRs1Data;
    logic [xlen-1:0] exeRs2Data;
    logic [xlen-1:0] exeImm;
    logic [6:0] exeFunct7;
    aluOpT exeAluOp;
    logic exeAluSrc;
    logic exeRdSrc;
    logic exeBranch;

    instrDecoder uDecoder (
        .instr(instr),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .writeAddr(writeAddr),
        .funct3(funct3),
        .funct7(funct7),
        .imm(imm),
        .aluOp(aluOp),
        .aluSrc(aluSrc),
        .rdSrc(rdSrc),
        .memtoReg(memtoReg),
        .memWrite(memWrite),
        .memRead(memRead),
        .regWrite(regWrite),
        .branch(branch)
    );

    regFile uRegFile (
        .clk(clk),
        .reset(reset),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .wbWe(wbWe),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    idExeReg uIdExe (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .pc(pc),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .imm(imm),
        .writeAddr(writeAddr),
        .funct3(funct3),
        .funct7(funct7),
        .aluOp(aluOp),
        .aluSrc(aluSrc),
        .rdSrc(rdSrc),
        .memtoReg(memtoReg),
        .memWrite(memWrite),
        .memRead(memRead),
        .regWrite(regWrite),
        .branch(branch),
        .exePc(exePc),
        .exeRs1Data(exeRs1Data),
        .exeRs2Data(exeRs2Data),
        .exeImm(exeImm),
        .exeWriteAddr(exeWriteAddr),
        .exeFunct3(exeFunct3),
        .exeFunct7(exeFunct7),
        .exeAluOp(exeAluOp),
        .exeAluSrc(exeAluSrc),
        .exeRdSrc(exeRdSrc),
        .exeMemtoReg(exeMemtoReg),
        .exeMemWrite(exeMemWrite),
        .exeMemRead(exeMemRead),
        .exeRegWrite(exeRegWrite),
        .exeBranch(exeBranch)
    );

    exeStage uExe (
        .exePc(exePc),
        .exeRs1Data(exeRs1Data),
        .exeRs2Data(exeRs2Data),
        .exeImm(exeImm),
        .exeFunct3(exeFunct3),
        .exeFunct7(exeFunct7),
        .exeAluOp(exeAluOp),
        .exeAluSrc(exeAluSrc),
        .exeRdSrc(exeRdSrc),
        .exeBranch(exeBranch),
        .exeResult(exeResult),
        .exeStoreData(exeStoreData),
        .branchTarget(branchTarget),
        .branchTaken(branchTaken)
    );

endmodule

// File: test/decodeExecuteTb.sv
`timescale 1ns/1ps

module decodeExecuteTb;
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;

    localparam int resetCycles = 4;
    localparam int preloadWrites = 8;

    logic clk;
    logic reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic flush;
    logic wbWe;
    logic [4:0] wbAddr;
    logic [31:0] wbData;
    logic [31:0] exeResult;
    logic [31:0] exeStoreData;
    logic [4:0] exeWriteAddr;
    logic [2:0] exeFunct3;
    logic exeRegWrite;
    logic exeMemRead;
    logic exeMemWrite;
    logic exeMemtoReg;
    logic branchTaken;
    logic [31:0] branchTarget;

    // register contents as the testbench expects them
    logic [31:0] regModel [0:31];

    // stimulus and expected values, one entry per row
    string rowName[$];
    logic [31:0] rowInstr[$];
    logic [31:0] rowPc[$];
    logic rowFlush[$];
    logic rowWbWe[$];
    logic [4:0] rowWbAddr[$];
    logic [31:0] rowWbData[$];
    logic [31:0] rowResult[$];
    logic [2:0] rowCtrl[$];
    logic rowTaken[$];
    logic [31:0] rowTarget[$];

    int cycles = 0;
    int cycleLimit = resetCycles + preloadWrites + 20;

    decodeExecuteTop u_dut (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .flush(flush),
        .wbWe(wbWe),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .exeResult(exeResult),
        .exeStoreData(exeStoreData),
        .exeWriteAddr(exeWriteAddr),
        .exeFunct3(exeFunct3),
        .exeRegWrite(exeRegWrite),
        .exeMemRead(exeMemRead),
        .exeMemWrite(exeMemWrite),
        .exeMemtoReg(exeMemtoReg),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Checks failed");
            $fatal(1, "timeout: the test sequence did not finish within %0d cycles", cycleLimit);
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] encI(input opcodeT op, input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input opcodeT op, input logic [19:0] imm,
            input logic [4:0] rd);
        return {imm, rd, op};
    endfunction

    // RV32I integer operations
    function automatic logic [31:0] refAlu(input aluFuncT fn, input logic [31:0] a,
            input logic [31:0] b);
        case (fn)
            fnSub: return a - b;
            fnSll: return a << b[4:0];
            fnSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fnSltu: return (a < b) ? 32'd1 : 32'd0;
            fnXor: return a ^ b;
            fnSrl: return a >> b[4:0];
            fnSra: return $signed(a) >>> b[4:0];
            fnOr: return a | b;
            fnAnd: return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            brEq: return a == b;
            brNe: return a != b;
            brLt: return $signed(a) < $signed(b);
            brGe: return $signed(a) >= $signed(b);
            brLtu: return a < b;
            brGeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] curPc();
        return 32'h0000_1000 + 32'(rowName.size()) * 4;
    endfunction

    // ctrl bits are regWrite, memRead, memWrite
    function automatic void addRow(input string name, input logic [31:0] word,
            input logic fl, input logic [31:0] result, input logic [2:0] ctrl,
            input logic taken, input logic [31:0] target);
        rowPc.push_back(curPc());
        rowName.push_back(name);
        rowInstr.push_back(word);
        rowFlush.push_back(fl);
        rowWbWe.push_back(1'b0);
        rowWbAddr.push_back(5'd0);
        rowWbData.push_back(32'h0);
        rowResult.push_back(result);
        rowCtrl.push_back(ctrl);
        rowTaken.push_back(taken);
        rowTarget.push_back(target);
    endfunction

    function automatic void aluRow(input string name, input aluFuncT fn,
            input logic [31:0] word, input logic [31:0] opB);
        addRow(name, word, 1'b0, refAlu(fn, regModel[word[19:15]], opB), 3'b100, 1'b0, 32'h0);
    endfunction

    function automatic void brRow(input string name, input branchCondT cond,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] off);
        addRow(name, encB(off, rs2, rs1, cond), 1'b0, 32'h0, 3'b000,
            refBranch(cond, regModel[rs1], regModel[rs2]), curPc() + sext13(off));
    endfunction

    function automatic void buildTable();
        for (int i = 0; i < 32; i++) begin
            regModel[i] = 32'h0;
        end
        regModel[1] = 32'h0000_0015;
        regModel[2] = 32'h0000_0003;
        regModel[3] = 32'hFFFF_FFF0;
        regModel[4] = 32'h8000_0001;
        regModel[5] = 32'h0000_0015;
        regModel[6] = 32'h1234_5678;
        regModel[7] = 32'h0000_0004;
        regModel[8] = 32'hFFFF_FF00;

        aluRow("add", fnAdd, encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), regModel[2]);
        aluRow("sub", fnSub, encR(7'h20, 5'd3, 5'd1, 3'd0, 5'd11), regModel[3]);
        aluRow("sll", fnSll, encR(7'h00, 5'd2, 5'd6, 3'd1, 5'd12), regModel[2]);
        aluRow("slt", fnSlt, encR(7'h00, 5'd1, 5'd3, 3'd2, 5'd13), regModel[1]);
        aluRow("sltu", fnSltu, encR(7'h00, 5'd1, 5'd3, 3'd3, 5'd14), regModel[1]);
        aluRow("xor", fnXor, encR(7'h00, 5'd8, 5'd6, 3'd4, 5'd15), regModel[8]);
        aluRow("srl", fnSrl, encR(7'h00, 5'd2, 5'd4, 3'd5, 5'd16), regModel[2]);
        aluRow("sra", fnSra, encR(7'h20, 5'd2, 5'd4, 3'd5, 5'd17), regModel[2]);
        aluRow("or", fnOr, encR(7'h00, 5'd3, 5'd6, 3'd6, 5'd18), regModel[3]);
        aluRow("and", fnAnd, encR(7'h00, 5'd8, 5'd6, 3'd7, 5'd19), regModel[8]);
        // negative immediates also set funct7 bit 5
        aluRow("addi", fnAdd, encI(opOpImm, 12'hFFB, 5'd1, 3'd0, 5'd20), sext12(12'hFFB));
        aluRow("slti", fnSlt, encI(opOpImm, 12'hFFF, 5'd1, 3'd2, 5'd21), sext12(12'hFFF));
        aluRow("sltiu", fnSltu, encI(opOpImm, 12'h7FF, 5'd1, 3'd3, 5'd22), sext12(12'h7FF));
        aluRow("xori", fnXor, encI(opOpImm, 12'hFFF, 5'd6, 3'd4, 5'd23), sext12(12'hFFF));
        aluRow("ori", fnOr, encI(opOpImm, 12'h0F0, 5'd1, 3'd6, 5'd24), sext12(12'h0F0));
        aluRow("andi", fnAnd, encI(opOpImm, 12'h0F0, 5'd6, 3'd7, 5'd25), sext12(12'h0F0));
        aluRow("slli", fnSll, encI(opOpImm, 12'h003, 5'd7, 3'd1, 5'd26), 32'd3);
        aluRow("srli", fnSrl, encI(opOpImm, 12'h004, 5'd4, 3'd5, 5'd27), 32'd4);
        aluRow("srai", fnSra, encI(opOpImm, 12'h404, 5'd4, 3'd5, 5'd28), 32'd4);

        addRow("lw", encI(opLoad, 12'hFFC, 5'd6, 3'd2, 5'd29), 1'b0,
            regModel[6] + sext12(12'hFFC), 3'b110, 1'b0, 32'h0);
        addRow("sw", encS(12'h008, 5'd3, 5'd1, 3'd2), 1'b0,
            regModel[1] + sext12(12'h008), 3'b001, 1'b0, 32'h0);
        addRow("sh negative offset", encS(12'hFF0, 5'd8, 5'd6, 3'd1), 1'b0,
            regModel[6] + sext12(12'hFF0), 3'b001, 1'b0, 32'h0);

        brRow("beq taken", brEq, 5'd1, 5'd5, 13'h0010);
        brRow("beq not taken", brEq, 5'd1, 5'd2, 13'h0010);
        brRow("bne taken", brNe, 5'd1, 5'd2, 13'h1FF8);
        brRow("bne not taken", brNe, 5'd1, 5'd5, 13'h1FF8);
        brRow("blt taken", brLt, 5'd3, 5'd1, 13'h0020);
        brRow("blt not taken", brLt, 5'd1, 5'd3, 13'h0020);
        brRow("bge taken", brGe, 5'd1, 5'd3, 13'h1F00);
        brRow("bge not taken", brGe, 5'd3, 5'd1, 13'h1F00);
        brRow("bltu taken", brLtu, 5'd1, 5'd3, 13'h0104);
        brRow("bltu not taken", brLtu, 5'd3, 5'd1, 13'h0104);
        brRow("bgeu taken", brGeu, 5'd3, 5'd1, 13'h1FFC);
        brRow("bgeu not taken", brGeu, 5'd1, 5'd3, 13'h1FFC);

        // the rs1 field of this lui points at x1
        addRow("lui", encU(opLui, 20'hABC0E, 5'd30), 1'b0, 32'hABC0_E000, 3'b100, 1'b0, 32'h0);
        addRow("auipc", encU(opAuipc, 20'h00012, 5'd31), 1'b0,
            curPc() + 32'h0001_2000, 3'b100, 1'b0, 32'h0);

        // x9 written and read in the same cycle
        addRow("write-through add", encR(7'h00, 5'd1, 5'd9, 3'd0, 5'd10), 1'b0,
            32'h0000_0777 + regModel[1], 3'b100, 1'b0, 32'h0);
        rowWbWe[rowWbWe.size() - 1] = 1'b1;
        rowWbAddr[rowWbAddr.size() - 1] = 5'd9;
        rowWbData[rowWbData.size() - 1] = 32'h0000_0777;

        addRow("flushed add", encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), 1'b1,
            32'h0, 3'b000, 1'b0, 32'h0);
        aluRow("sub after flush", fnSub, encR(7'h20, 5'd7, 5'd6, 3'd0, 5'd11), regModel[7]);
    endfunction

    task automatic checkVal(input string test, input string field, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", test, field, expected, actual);
            $display("Checks failed");
            $fatal(1, "value mismatch in test %s", test);
        end
    endtask

    task automatic checkBubble(input string test);
        checkVal(test, "exeResult", 32'h0, exeResult);
        checkVal(test, "branchTaken", 32'h0, 32'(branchTaken));
        checkVal(test, "control", 32'h0,
            32'({exeRegWrite, exeMemRead, exeMemWrite, exeMemtoReg}));
    endtask

    task automatic applyRow(input int i);
        instr = rowInstr[i];
        pc = rowPc[i];
        flush = rowFlush[i];
        wbWe = rowWbWe[i];
        wbAddr = rowWbAddr[i];
        wbData = rowWbData[i];
    endtask

    task automatic checkRow(input int i);
        logic isBranch;
        logic isStore;
        logic [31:0] word;
        word = rowInstr[i];
        isBranch = !rowFlush[i] && (word[6:0] == opBranch);
        isStore = !rowFlush[i] && (word[6:0] == opStore);
        if (!isBranch) begin
            checkVal(rowName[i], "exeResult", rowResult[i], exeResult);
        end
        if (isStore || rowFlush[i]) begin
            checkVal(rowName[i], "exeStoreData",
                rowFlush[i] ? 32'h0 : regModel[word[24:20]], exeStoreData);
        end
        if (isBranch || rowFlush[i]) begin
            checkVal(rowName[i], "branchTarget", rowTarget[i], branchTarget);
        end
        checkVal(rowName[i], "exeWriteAddr",
            rowFlush[i] ? 32'h0 : 32'(word[11:7]), 32'(exeWriteAddr));
        checkVal(rowName[i], "exeFunct3",
            rowFlush[i] ? 32'h0 : 32'(word[14:12]), 32'(exeFunct3));
        checkVal(rowName[i], "control", 32'(rowCtrl[i]),
            32'({exeRegWrite, exeMemRead, exeMemWrite}));
        checkVal(rowName[i], "exeMemtoReg", 32'(rowCtrl[i][1]), 32'(exeMemtoReg));
        checkVal(rowName[i], "branchTaken", 32'(rowTaken[i]), 32'(branchTaken));
    endtask

    initial begin
        reset = 1'b1;
        instr = 32'h0;
        pc = 32'h0;
        flush = 1'b0;
        wbWe = 1'b0;
        wbAddr = 5'd0;
        wbData = 32'h0;
        buildTable();
        cycleLimit = resetCycles + preloadWrites + rowName.size() + 20;

        repeat (resetCycles) @(posedge clk);
        #1;
        checkBubble("during reset");
        reset = 1'b0;
        @(posedge clk);
        #1;
        checkBubble("after reset");

        for (int r = 1; r <= preloadWrites; r++) begin
            wbWe = 1'b1;
            wbAddr = 5'(r);
            wbData = regModel[r];
            @(posedge clk);
            #1;
        end
        wbWe = 1'b0;

        // one row per cycle, checked one edge later
        for (int i = 0; i < rowName.size(); i++) begin
            applyRow(i);
            @(posedge clk);
            #1;
            checkRow(i);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: sources.f
rtl/rvIsaPkg.sv
rtl/pipeCtrlPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/idExeReg.sv
rtl/exeStage.sv
rtl/decodeExecuteTop.sv
test/decodeExecuteTb.sv
